//--- hdl/exu_pkg.sv
`default_nettype none

package exu_pkg;

  // rv major opcodes
  typedef enum logic [6:0] {
    OP_ALU    = 7'b0110011,
    OP_ALUI   = 7'b0010011,
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  // SLE/SLEU are the >= tests behind bge/bgeu
  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    SLL  = 4'd2,
    SRL  = 4'd3,
    SRA  = 4'd4,
    AND  = 4'd5,
    OR   = 4'd6,
    XOR  = 4'd7,
    SLT  = 4'd8,
    SLTU = 4'd9,
    SLE  = 4'd10,
    SLEU = 4'd11
  } alu_op_e;

  // funct3 of system instructions, carried in imm[3:0]
  typedef enum logic [2:0] {
    PRIV   = 3'b000,
    CSRRW  = 3'b001,
    CSRRS  = 3'b010,
    CSRRC  = 3'b011,
    CSRRWI = 3'b101,
    CSRRSI = 3'b110,
    CSRRCI = 3'b111
  } sys_funct_e;

  // funct12 of PRIV instructions, carried in imm[15:4]
  localparam logic [11:0] F12_ECALL  = 12'h000;
  localparam logic [11:0] F12_EBREAK = 12'h001;
  localparam logic [11:0] F12_MRET   = 12'h302;

  localparam logic [11:0] CSR_MSTATUS = 12'h300;
  localparam logic [11:0] CSR_MTVEC   = 12'h305;
  localparam logic [11:0] CSR_MEPC    = 12'h341;
  localparam logic [11:0] CSR_MCAUSE  = 12'h342;

  // mstatus bit positions
  localparam int MSTATUS_MIE  = 3;
  localparam int MSTATUS_MPIE = 7;

  // environment call from m-mode
  localparam int unsigned CAUSE_ECALL_M = 11;

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    REQ  = 2'd1,
    DONE = 2'd2
  } mem_state_e;

endpackage

`default_nettype wire

//--- hdl/lsu_if.sv
`timescale 1ns/100ps
`default_nettype none

interface lsu_if #(
  parameter int XLEN = 64
);
  logic            req;
  logic            we;
  logic [XLEN-1:0] addr;
  logic [XLEN-1:0] wdata;
  logic [XLEN-1:0] rdata;
  logic            ack;

  // execute stage side
  modport master (
    output req, we, addr, wdata,
    input  rdata, ack
  );

  // ram side
  modport slave (
    input  req, we, addr, wdata,
    output rdata, ack
  );
endinterface

`default_nettype wire

//--- hdl/exu_alu.sv
`timescale 1ns/100ps
`default_nettype none

module exu_alu #(
  parameter int XLEN = 64
) (
  input  logic [XLEN-1:0]  src1_i,
  input  logic [XLEN-1:0]  src2_i,
  input  exu_pkg::alu_op_e op_i,
  output logic [XLEN-1:0]  res_o
);
  import exu_pkg::*;

  localparam int SHW = $clog2(XLEN);

  logic [SHW-1:0] shamt;
  logic           lt;
  logic           ltu;

  assign shamt = src2_i[SHW-1:0];
  assign lt    = $signed(src1_i) < $signed(src2_i);
  assign ltu   = src1_i < src2_i;

  always_comb begin
    case (op_i)
      ADD:  res_o = src1_i + src2_i;
      SUB:  res_o = src1_i - src2_i;
      SLL:  res_o = src1_i << shamt;
      SRL:  res_o = src1_i >> shamt;
      SRA:  res_o = $signed(src1_i) >>> shamt;
      AND:  res_o = src1_i & src2_i;
      OR:   res_o = src1_i | src2_i;
      XOR:  res_o = src1_i ^ src2_i;
      SLT:  res_o = XLEN'(lt);
      SLTU: res_o = XLEN'(ltu);
      // greater or equal, for bge/bgeu
      SLE:  res_o = XLEN'(!lt);
      SLEU: res_o = XLEN'(!ltu);
      default: res_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/exu_csr.sv
`timescale 1ns/100ps
`default_nettype none

module exu_csr #(
  parameter int XLEN = 64
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            wen_i,
  input  logic [11:0]     addr_i,
  input  logic [XLEN-1:0] wdata_i,
  input  logic            ecall_i,
  input  logic [XLEN-1:0] epc_i,
  output logic [XLEN-1:0] rdata_o,
  output logic [XLEN-1:0] mtvec_o,
  output logic [XLEN-1:0] mepc_o
);
  import exu_pkg::*;

  logic [XLEN-1:0] mstatus_q;
  logic [XLEN-1:0] mtvec_q;
  logic [XLEN-1:0] mepc_q;
  logic [XLEN-1:0] mcause_q;

  always_comb begin
    case (addr_i)
      CSR_MSTATUS: rdata_o = mstatus_q;
      CSR_MTVEC:   rdata_o = mtvec_q;
      CSR_MEPC:    rdata_o = mepc_q;
      CSR_MCAUSE:  rdata_o = mcause_q;
      default:     rdata_o = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= '0;
      mtvec_q   <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else begin
      if (wen_i || ecall_i) begin
        case (addr_i)
          CSR_MSTATUS: mstatus_q <= wdata_i;
          CSR_MTVEC:   mtvec_q   <= wdata_i;
          CSR_MEPC:    mepc_q    <= wdata_i;
          CSR_MCAUSE:  mcause_q  <= wdata_i;
          default: begin
          end
        endcase
      end
      // trap pc lands in mepc alongside the cause write
      if (ecall_i) begin
        mepc_q <= epc_i;
      end
    end
  end

  assign mtvec_o = mtvec_q;
  assign mepc_o  = mepc_q;

endmodule

`default_nettype wire

//--- hdl/exu_stage.sv
`timescale 1ns/100ps
`default_nettype none

module exu_stage #(
  parameter int XLEN = 64
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              prev_valid_i,
  output logic              ready_o,
  input  exu_pkg::opcode_e  opcode_i,
  input  exu_pkg::alu_op_e  alu_op_i,
  input  logic [XLEN-1:0]   op1_i,
  input  logic [XLEN-1:0]   op2_i,
  input  logic [XLEN-1:0]   op_j_i,
  input  logic [XLEN-1:0]   imm_i,
  input  logic [XLEN-1:0]   pc_i,
  input  logic [XLEN-1:0]   rwaddr_i,
  input  logic [4:0]        rd_i,
  input  logic              ren_i,
  input  logic              wen_i,
  output logic              valid_o,
  input  logic              next_ready_i,
  output logic [4:0]        rd_o,
  output logic [XLEN-1:0]   reg_wdata_o,
  output logic [XLEN-1:0]   npc_o,
  output logic              use_npc_o,
  output logic              ebreak_o,
  output logic [XLEN-1:0]   pc_o,
  output logic [XLEN-1:0]   alu_src1_o,
  output logic [XLEN-1:0]   alu_src2_o,
  output exu_pkg::alu_op_e  alu_op_o,
  input  logic [XLEN-1:0]   alu_res_i,
  output logic              csr_wen_o,
  output logic [11:0]       csr_addr_o,
  output logic [XLEN-1:0]   csr_wdata_o,
  output logic              csr_ecall_o,
  output logic [XLEN-1:0]   csr_epc_o,
  input  logic [XLEN-1:0]   csr_rdata_i,
  input  logic [XLEN-1:0]   mtvec_i,
  input  logic [XLEN-1:0]   mepc_i,
  lsu_if.master             lsu
);
  import exu_pkg::*;

  opcode_e         opcode_q;
  alu_op_e         alu_op_q;
  logic [XLEN-1:0] src1_q;
  logic [XLEN-1:0] src2_q;
  logic [XLEN-1:0] imm_q;
  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] jmp_q;
  logic [XLEN-1:0] rwaddr_q;
  logic [4:0]      rd_q;
  logic            ren_q;
  logic            wen_q;
  logic [XLEN-1:0] mem_rdata_q;
  logic            full_q;
  mem_state_e      state_q;

  logic            accept;
  logic            drain;
  logic            is_mem;
  logic            is_sys;
  logic            is_ecall;
  logic            is_mret;
  logic            is_ebreak;
  logic            take;
  sys_funct_e      funct;
  logic [11:0]     f12;

  assign is_mem  = ren_q | wen_q;
  assign valid_o = full_q && (!is_mem || state_q == DONE);
  assign drain   = valid_o && next_ready_i;
  assign ready_o = !full_q || drain;
  assign accept  = prev_valid_i && ready_o;

  // payload latch
  always_ff @(posedge clk) begin
    if (accept) begin
      opcode_q <= opcode_i;
      alu_op_q <= alu_op_i;
      src1_q   <= op1_i;
      src2_q   <= op2_i;
      imm_q    <= imm_i;
      pc_q     <= pc_i;
      jmp_q    <= op_j_i + imm_i;
      rwaddr_q <= rwaddr_i;
      rd_q     <= rd_i;
      ren_q    <= ren_i;
      wen_q    <= wen_i;
    end
    if (state_q == REQ && lsu.ack) begin
      mem_rdata_q <= lsu.rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      full_q  <= 1'b0;
      state_q <= IDLE;
    end else begin
      if (accept) begin
        full_q <= 1'b1;
      end else if (drain) begin
        full_q <= 1'b0;
      end
      case (state_q)
        IDLE: begin
          if (accept && (ren_i || wen_i)) begin
            state_q <= REQ;
          end
        end
        REQ: begin
          if (lsu.ack) begin
            state_q <= DONE;
          end
        end
        DONE: begin
          // back to back memory ops skip idle
          if (drain) begin
            state_q <= (accept && (ren_i || wen_i)) ? REQ : IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  assign lsu.req   = (state_q == REQ);
  assign lsu.we    = wen_q;
  assign lsu.addr  = rwaddr_q;
  assign lsu.wdata = src2_q;

  assign alu_src1_o = src1_q;
  assign alu_src2_o = src2_q;
  assign alu_op_o   = alu_op_q;

  // system decode from imm
  assign funct     = sys_funct_e'(imm_q[2:0]);
  assign f12       = imm_q[15:4];
  assign is_sys    = (opcode_q == OP_SYSTEM);
  assign is_ecall  = is_sys && funct == PRIV && f12 == F12_ECALL;
  assign is_mret   = is_sys && funct == PRIV && f12 == F12_MRET;
  assign is_ebreak = is_sys && funct == PRIV && f12 == F12_EBREAK;

  assign csr_addr_o  = is_ecall ? CSR_MCAUSE : is_mret ? CSR_MSTATUS : f12;
  assign csr_wen_o   = drain && is_sys && (funct != PRIV || is_ecall || is_mret);
  assign csr_ecall_o = drain && is_ecall;
  assign csr_epc_o   = pc_q;

  always_comb begin
    csr_wdata_o = '0;
    case (funct)
      CSRRW, CSRRWI: csr_wdata_o = src1_q;
      CSRRS, CSRRSI: csr_wdata_o = csr_rdata_i | src1_q;
      CSRRC, CSRRCI: csr_wdata_o = csr_rdata_i & ~src1_q;
      PRIV: begin
        if (is_ecall) begin
          csr_wdata_o = XLEN'(CAUSE_ECALL_M);
        end else if (is_mret) begin
          // mie <- mpie, mpie <- 1
          csr_wdata_o = csr_rdata_i;
          csr_wdata_o[MSTATUS_MIE]  = csr_rdata_i[MSTATUS_MPIE];
          csr_wdata_o[MSTATUS_MPIE] = 1'b1;
        end
      end
      default: csr_wdata_o = '0;
    endcase
  end

  assign reg_wdata_o = ren_q ? mem_rdata_q : is_sys ? csr_rdata_i : alu_res_i;

  always_comb begin
    npc_o = jmp_q;
    take  = 1'b0;
    case (opcode_q)
      OP_JAL, OP_JALR: take = 1'b1;
      OP_BRANCH: begin
        // beq compares via sub, the rest via a nonzero flag
        if (alu_op_q == SUB) begin
          take = (alu_res_i == '0);
        end else begin
          take = (alu_res_i != '0);
        end
      end
      OP_SYSTEM: begin
        if (is_ecall) begin
          take  = 1'b1;
          npc_o = mtvec_i;
        end else if (is_mret) begin
          take  = 1'b1;
          npc_o = mepc_i;
        end
      end
      default: take = 1'b0;
    endcase
  end

  assign use_npc_o = valid_o && take;
  assign ebreak_o  = valid_o && is_ebreak;
  assign rd_o      = rd_q;
  assign pc_o      = pc_q;

endmodule

`default_nettype wire

//--- hdl/data_ram.sv
`timescale 1ns/100ps
`default_nettype none

module data_ram #(
  parameter int XLEN        = 64,
  parameter int MEM_DEPTH   = 256,
  parameter int MEM_LATENCY = 2
) (
  input  logic  clk,
  input  logic  rst,
  lsu_if.slave  lsu
);
  localparam int AW = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;
  localparam int CW = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;

  logic [XLEN-1:0] mem_q [MEM_DEPTH];
  logic [XLEN-1:0] rdata_q;
  logic [CW-1:0]   cnt_q;
  logic            ack_q;
  logic [AW-1:0]   idx;
  logic            last;

  assign idx  = AW'(lsu.addr % XLEN'(MEM_DEPTH));
  // final wait cycle, access happens at its edge
  assign last = lsu.req && !ack_q && cnt_q == CW'(MEM_LATENCY - 1);

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_q <= '0;
      ack_q <= 1'b0;
    end else begin
      ack_q <= last;
      if (last) begin
        cnt_q <= '0;
      end else if (lsu.req && !ack_q) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (last) begin
      if (lsu.we) begin
        mem_q[idx] <= lsu.wdata;
      end
      rdata_q <= mem_q[idx];
    end
  end

  assign lsu.ack   = ack_q;
  assign lsu.rdata = rdata_q;

endmodule

`default_nettype wire

//--- hdl/exu_top.sv
`timescale 1ns/100ps
`default_nettype none

module exu_top #(
  parameter int XLEN        = 64,
  parameter int MEM_DEPTH   = 256,
  parameter int MEM_LATENCY = 2
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              prev_valid_i,
  output logic              ready_o,
  input  exu_pkg::opcode_e  opcode_i,
  input  exu_pkg::alu_op_e  alu_op_i,
  input  logic [XLEN-1:0]   op1_i,
  input  logic [XLEN-1:0]   op2_i,
  input  logic [XLEN-1:0]   op_j_i,
  input  logic [XLEN-1:0]   imm_i,
  input  logic [XLEN-1:0]   pc_i,
  input  logic [XLEN-1:0]   rwaddr_i,
  input  logic [4:0]        rd_i,
  input  logic              ren_i,
  input  logic              wen_i,
  output logic              valid_o,
  input  logic              next_ready_i,
  output logic [4:0]        rd_o,
  output logic [XLEN-1:0]   reg_wdata_o,
  output logic [XLEN-1:0]   npc_o,
  output logic              use_npc_o,
  output logic              ebreak_o,
  output logic [XLEN-1:0]   pc_o
);
  logic [XLEN-1:0]  alu_src1;
  logic [XLEN-1:0]  alu_src2;
  exu_pkg::alu_op_e alu_op;
  logic [XLEN-1:0]  alu_res;
  logic             csr_wen;
  logic [11:0]      csr_addr;
  logic [XLEN-1:0]  csr_wdata;
  logic             csr_ecall;
  logic [XLEN-1:0]  csr_epc;
  logic [XLEN-1:0]  csr_rdata;
  logic [XLEN-1:0]  mtvec;
  logic [XLEN-1:0]  mepc;

  lsu_if #(.XLEN(XLEN)) lsu0 ();

  exu_stage #(.XLEN(XLEN)) stage0 (
    .clk, .rst, .prev_valid_i, .ready_o,
    .opcode_i, .alu_op_i, .op1_i, .op2_i, .op_j_i, .imm_i, .pc_i, .rwaddr_i,
    .rd_i, .ren_i, .wen_i, .valid_o, .next_ready_i,
    .rd_o, .reg_wdata_o, .npc_o, .use_npc_o, .ebreak_o, .pc_o,
    .alu_src1_o(alu_src1), .alu_src2_o(alu_src2), .alu_op_o(alu_op), .alu_res_i(alu_res),
    .csr_wen_o(csr_wen), .csr_addr_o(csr_addr), .csr_wdata_o(csr_wdata),
    .csr_ecall_o(csr_ecall), .csr_epc_o(csr_epc), .csr_rdata_i(csr_rdata),
    .mtvec_i(mtvec), .mepc_i(mepc),
    .lsu(lsu0.master)
  );

  exu_alu #(.XLEN(XLEN)) alu0 (
    .src1_i(alu_src1), .src2_i(alu_src2), .op_i(alu_op), .res_o(alu_res)
  );

  exu_csr #(.XLEN(XLEN)) csr0 (
    .clk, .rst,
    .wen_i(csr_wen), .addr_i(csr_addr), .wdata_i(csr_wdata),
    .ecall_i(csr_ecall), .epc_i(csr_epc),
    .rdata_o(csr_rdata), .mtvec_o(mtvec), .mepc_o(mepc)
  );

  data_ram #(
    .XLEN(XLEN), .MEM_DEPTH(MEM_DEPTH), .MEM_LATENCY(MEM_LATENCY)
  ) ram0 (
    .clk, .rst, .lsu(lsu0.slave)
  );

endmodule

`default_nettype wire

//--- dv/exu_tb.sv
`timescale 1ns/100ps
`default_nettype none

module exu_tb;
  import exu_pkg::*;

  localparam int XLEN        = 64;
  localparam int MEM_DEPTH   = 256;
  localparam int MEM_LATENCY = 2;
  localparam int MAXN        = 256;

  logic             clk;
  logic             rst;
  logic             prev_valid_i;
  logic             ready_o;
  opcode_e          opcode_i;
  alu_op_e          alu_op_i;
  logic [XLEN-1:0]  op1_i;
  logic [XLEN-1:0]  op2_i;
  logic [XLEN-1:0]  op_j_i;
  logic [XLEN-1:0]  imm_i;
  logic [XLEN-1:0]  pc_i;
  logic [XLEN-1:0]  rwaddr_i;
  logic [4:0]       rd_i;
  logic             ren_i;
  logic             wen_i;
  logic             valid_o;
  logic             next_ready_i;
  logic [4:0]       rd_o;
  logic [XLEN-1:0]  reg_wdata_o;
  logic [XLEN-1:0]  npc_o;
  logic             use_npc_o;
  logic             ebreak_o;
  logic [XLEN-1:0]  pc_o;

  // program and expected results filled before reset ends
  opcode_e          prg_opc [MAXN];
  alu_op_e          prg_aop [MAXN];
  logic [XLEN-1:0]  prg_a   [MAXN];
  logic [XLEN-1:0]  prg_b   [MAXN];
  logic [XLEN-1:0]  prg_j   [MAXN];
  logic [XLEN-1:0]  prg_imm [MAXN];
  logic [XLEN-1:0]  prg_pc  [MAXN];
  logic [XLEN-1:0]  prg_adr [MAXN];
  logic [4:0]       prg_rd  [MAXN];
  logic             prg_ren [MAXN];
  logic             prg_wen [MAXN];
  logic [XLEN-1:0]  exp_w   [MAXN];
  logic             chk_w   [MAXN];
  logic             exp_use [MAXN];
  logic [XLEN-1:0]  exp_npc [MAXN];
  logic             exp_eb  [MAXN];
  int               exp_lat [MAXN];
  int               acc_cyc [MAXN];

  // reference state
  logic [XLEN-1:0]  csr_m [5];
  logic [XLEN-1:0]  mem_m [MEM_DEPTH];

  logic [31:0]      lfsr;
  int               n_total;
  int               nd;
  int               n_acc;
  int               cyc;
  int               limit;
  logic             seen;
  logic             drain;
  logic             accept;

  exu_top dut0 (.*);

  assign drain  = valid_o && next_ready_i;
  assign accept = prev_valid_i && ready_o;

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [63:0] rand_bits(int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r = {r[62:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [63:0] alu_ref(alu_op_e op, logic [63:0] a, logic [63:0] b);
    logic [5:0] sh;
    sh = b[5:0];
    case (op)
      ADD:  return a + b;
      SUB:  return a - b;
      SLL:  return a << sh;
      SRL:  return a >> sh;
      SRA:  return $signed(a) >>> sh;
      AND:  return a & b;
      OR:   return a | b;
      XOR:  return a ^ b;
      SLT:  return {63'b0, $signed(a) < $signed(b)};
      SLTU: return {63'b0, a < b};
      SLE:  return {63'b0, $signed(a) >= $signed(b)};
      SLEU: return {63'b0, a >= b};
      default: return '0;
    endcase
  endfunction

  function automatic int csr_slot(logic [11:0] addr);
    case (addr)
      CSR_MSTATUS: return 0;
      CSR_MTVEC:   return 1;
      CSR_MEPC:    return 2;
      CSR_MCAUSE:  return 3;
      default:     return 4;
    endcase
  endfunction

  task automatic stop_failed(string line);
    $display("%s", line);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic report_error(string msg);
    stop_failed($sformatf("** Error at %0t: %s", $time, msg));
  endtask

  task automatic push(opcode_e opc, alu_op_e aop, logic [63:0] a, logic [63:0] b,
                      logic [63:0] imm, logic ren, logic wen);
    int i;
    i = n_total;
    prg_opc[i] = opc;
    prg_aop[i] = aop;
    prg_a[i]   = a;
    prg_b[i]   = b;
    prg_j[i]   = rand_bits(64);
    prg_imm[i] = imm;
    prg_pc[i]  = rand_bits(64);
    prg_adr[i] = rand_bits(64);
    prg_rd[i]  = 5'(rand_bits(5));
    prg_ren[i] = ren;
    prg_wen[i] = wen;
    chk_w[i]   = 1'b0;
    exp_use[i] = 1'b0;
    exp_npc[i] = '0;
    exp_eb[i]  = 1'b0;
    exp_lat[i] = (ren || wen) ? MEM_LATENCY + 2 : 1;
    n_total++;
  endtask

  task automatic add_csr(sys_funct_e f, logic [11:0] addr, logic [63:0] src);
    int s;
    logic [63:0] old;
    s = csr_slot(addr);
    old = csr_m[s];
    push(OP_SYSTEM, ADD, src, '0, {48'b0, addr, 1'b0, f}, 1'b0, 1'b0);
    exp_w[n_total-1] = old;
    chk_w[n_total-1] = 1'b1;
    if (s != 4) begin
      case (f)
        CSRRW, CSRRWI: csr_m[s] = src;
        CSRRS, CSRRSI: csr_m[s] = old | src;
        default:       csr_m[s] = old & ~src;
      endcase
    end
  endtask

  task automatic build_program();
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] st;
    alu_op_e     op;
    alu_op_e     br_ops [6];
    int          i;
    br_ops = '{SUB, XOR, SLT, SLTU, SLE, SLEU};
    // alu ops
    for (int k = 0; k < 12; k++) begin
      op = alu_op_e'(4'(k));
      for (int r = 0; r < 3; r++) begin
        a = rand_bits(64);
        b = rand_bits(64);
        push(OP_ALU, op, a, b, '0, 1'b0, 1'b0);
        exp_w[n_total-1] = alu_ref(op, a, b);
        chk_w[n_total-1] = 1'b1;
      end
    end
    // branches with equal operands on every other one
    for (int k = 0; k < 6; k++) begin
      for (int r = 0; r < 4; r++) begin
        a = rand_bits(64);
        b = r[0] ? a : rand_bits(64);
        push(OP_BRANCH, br_ops[k], a, b, rand_bits(64), 1'b0, 1'b0);
        i = n_total - 1;
        exp_use[i] = (br_ops[k] == SUB) ? (a == b) : (alu_ref(br_ops[k], a, b) != '0);
        exp_npc[i] = prg_j[i] + prg_imm[i];
      end
    end
    push(OP_JAL, ADD, '0, '0, rand_bits(64), 1'b0, 1'b0);
    push(OP_JALR, ADD, '0, '0, rand_bits(64), 1'b0, 1'b0);
    for (int k = n_total - 2; k < n_total; k++) begin
      exp_use[k] = 1'b1;
      exp_npc[k] = prg_j[k] + prg_imm[k];
    end
    // store then load the same word
    for (int r = 0; r < 8; r++) begin
      b = rand_bits(64);
      push(OP_STORE, ADD, '0, b, '0, 1'b0, 1'b1);
      a = prg_adr[n_total-1];
      mem_m[a % MEM_DEPTH] = b;
      push(OP_LOAD, ADD, '0, '0, '0, 1'b1, 1'b0);
      prg_adr[n_total-1] = a;
      exp_w[n_total-1] = mem_m[a % MEM_DEPTH];
      chk_w[n_total-1] = 1'b1;
    end
    // csr read-modify-write on each csr and on unimplemented 12'h7c0
    foreach (br_ops[k]) begin
      if (k < 5) begin
        a = (k == 4) ? 64'h7c0 : (k == 0) ? CSR_MSTATUS : (k == 1) ? CSR_MTVEC :
            (k == 2) ? CSR_MEPC : CSR_MCAUSE;
        add_csr(CSRRW, a[11:0], rand_bits(64));
        add_csr(CSRRS, a[11:0], rand_bits(64));
        add_csr(CSRRC, a[11:0], rand_bits(64));
        add_csr(CSRRCI, a[11:0], 64'(rand_bits(5)));
        add_csr(CSRRS, a[11:0], '0);
      end
    end
    // traps
    add_csr(CSRRW, CSR_MTVEC, rand_bits(64));
    push(OP_SYSTEM, ADD, '0, '0, {48'b0, F12_ECALL, 1'b0, PRIV}, 1'b0, 1'b0);
    i = n_total - 1;
    exp_use[i] = 1'b1;
    exp_npc[i] = csr_m[1];
    csr_m[3] = 64'd11;
    csr_m[2] = prg_pc[i];
    add_csr(CSRRS, CSR_MEPC, '0);
    add_csr(CSRRS, CSR_MCAUSE, '0);
    // mpie clear and mie set, so both mret updates change a bit
    st = rand_bits(64);
    st[7] = 1'b0;
    st[3] = 1'b1;
    add_csr(CSRRW, CSR_MSTATUS, st);
    push(OP_SYSTEM, ADD, '0, '0, {48'b0, F12_MRET, 1'b0, PRIV}, 1'b0, 1'b0);
    i = n_total - 1;
    exp_use[i] = 1'b1;
    exp_npc[i] = csr_m[2];
    csr_m[0][3] = csr_m[0][7];
    csr_m[0][7] = 1'b1;
    add_csr(CSRRS, CSR_MSTATUS, '0);
    push(OP_SYSTEM, ADD, '0, '0, {48'b0, F12_EBREAK, 1'b0, PRIV}, 1'b0, 1'b0);
    exp_eb[n_total-1] = 1'b1;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      next_ready_i <= 1'b1;
    end else begin
      // stall about one cycle in four
      next_ready_i <= |rand_bits(2);
    end
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= limit) begin
      stop_failed("timeout: instructions did not drain in time");
    end else if (rst) begin
      nd    <= 0;
      n_acc <= 0;
      seen  <= 1'b0;
    end else begin
      if (drain) begin
        nd <= nd + 1;
      end
      if (accept) begin
        n_acc <= n_acc + 1;
        acc_cyc[n_acc] <= cyc;
      end
      seen <= valid_o && !next_ready_i;
    end
  end

  a_count: assert property (@(posedge clk) disable iff (rst) drain |-> nd < n_total)
    else report_error("extra instruction drained");
  a_wdata: assert property (@(posedge clk) disable iff (rst)
    drain |-> (!chk_w[nd] || reg_wdata_o == exp_w[nd]))
    else report_error($sformatf("reg_wdata_o %h, expected %h", reg_wdata_o, exp_w[nd]));
  a_npc: assert property (@(posedge clk) disable iff (rst)
    drain |-> use_npc_o == exp_use[nd] && (!exp_use[nd] || npc_o == exp_npc[nd]))
    else report_error($sformatf("use_npc_o %b npc_o %h, expected %b %h",
                                use_npc_o, npc_o, exp_use[nd], exp_npc[nd]));
  a_ids: assert property (@(posedge clk) disable iff (rst)
    drain |-> ebreak_o == exp_eb[nd] && rd_o == prg_rd[nd] && pc_o == prg_pc[nd])
    else report_error($sformatf("ebreak_o, rd_o or pc_o wrong for instruction %0d", nd));
  a_lat: assert property (@(posedge clk) disable iff (rst)
    valid_o && !seen |-> cyc - acc_cyc[nd] == exp_lat[nd])
    else report_error($sformatf("valid_o after %0d cycles, expected %0d",
                                cyc - acc_cyc[nd], exp_lat[nd]));
  a_stall: assert property (@(posedge clk) disable iff (rst)
    valid_o && !next_ready_i |-> !ready_o)
    else report_error("ready_o high during a stall");
  a_hold: assert property (@(posedge clk) disable iff (rst)
    valid_o && !next_ready_i |=> valid_o && $stable(reg_wdata_o) && $stable(npc_o) &&
    $stable(use_npc_o) && $stable(ebreak_o) && $stable(rd_o) && $stable(pc_o))
    else report_error("outputs changed during a stall");

  initial begin
    lfsr         = 32'h88726f41;
    n_total      = 0;
    cyc          = 0;
    limit        = 1000000;
    rst          = 1'b1;
    prev_valid_i = 1'b0;
    opcode_i     = OP_ALU;
    alu_op_i     = ADD;
    op1_i        = '0;
    op2_i        = '0;
    op_j_i       = '0;
    imm_i        = '0;
    pc_i         = '0;
    rwaddr_i     = '0;
    rd_i         = '0;
    ren_i        = 1'b0;
    wen_i        = 1'b0;
    next_ready_i = 1'b1;
    for (int k = 0; k < 5; k++) begin
      csr_m[k] = '0;
    end
    build_program();
    limit = n_total * (MEM_LATENCY + 10) + 100;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < n_total; i++) begin
      prev_valid_i <= 1'b1;
      opcode_i     <= prg_opc[i];
      alu_op_i     <= prg_aop[i];
      op1_i        <= prg_a[i];
      op2_i        <= prg_b[i];
      op_j_i       <= prg_j[i];
      imm_i        <= prg_imm[i];
      pc_i         <= prg_pc[i];
      rwaddr_i     <= prg_adr[i];
      rd_i         <= prg_rd[i];
      ren_i        <= prg_ren[i];
      wen_i        <= prg_wen[i];
      @(posedge clk);
      while (!ready_o) @(posedge clk);
    end
    prev_valid_i <= 1'b0;
    while (nd < n_total) @(posedge clk);
    @(posedge clk);
    if (nd == n_total && n_acc == n_total) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      stop_failed("instruction count mismatch between accepted and drained");
    end
  end

endmodule

`default_nettype wire

//--- list.f
hdl/exu_pkg.sv
hdl/lsu_if.sv
hdl/exu_alu.sv
hdl/exu_csr.sv
hdl/exu_stage.sv
hdl/data_ram.sv
hdl/exu_top.sv
dv/exu_tb.sv

//--- run.sh
#!/bin/sh
# build and run the execute stage testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f list.f --top-module exu_tb -o exu_sim
./obj_dir/exu_sim
